// File: src/zap_bus_pkg.sv
/* Bus word, byte-select, cycle-type and request payload types for the bus front end.
   Imported by the merger and the top level. */

package zap_bus_pkg;

// ------------------------------
// Basic bus types.
// ------------------------------

typedef logic [31:0] word_t;            // Address or data word.
typedef logic [3:0]  sel_t;             // One bit per byte lane.
typedef logic [2:0]  cti_t;             // Wishbone cycle type.

// ------------------------------
// Bus constants.
// ------------------------------

// End of burst. The only cycle type driven onto the bus.
localparam cti_t CTI_EOB = 3'b111;

localparam logic [1:0] BTE_LINEAR = 2'b00;      // Linear burst.

// Instruction fetches are word aligned.
localparam word_t WORD_ALIGN_MASK = 32'hFFFF_FFFC;

// ------------------------------
// Request payloads.
// ------------------------------

// Instruction fetch, a read of one word.
typedef struct packed
{
        word_t adr;                     // Fetch address.
} code_req_t;

// Load or store from the data port.
typedef struct packed
{
        word_t adr;                     // Byte address.
        logic  we;                      // Write enable.
        sel_t  sel;                     // Core lane order.
        word_t wdat;                    // Store data.
} data_req_t;

endpackage

// File: src/zap_irq_sync.sv
/* Dual-rank synchronizer for level-triggered interrupt inputs.
   Each bit reaches the output two clock edges after it is sampled. */

module zap_irq_sync #(
        parameter int unsigned WIDTH = 2
) (
        input  logic             i_clk,
        input  logic             i_rst_n,
        input  logic [WIDTH-1:0] i_async,
        output logic [WIDTH-1:0] o_sync
);

// ------------------------------
// Two flop ranks.
// ------------------------------

logic [WIDTH-1:0] meta_q;       // First rank, may go metastable.
logic [WIDTH-1:0] sync_q;       // Second rank, settled.

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                meta_q <= '0;
                sync_q <= '0;
        end
        else
        begin
                meta_q <= i_async;
                sync_q <= meta_q;
        end
end

assign o_sync = sync_q;

endmodule

// File: src/zap_req_hold.sv
/* Holds one core request stable until the merger completes it, then returns
   a registered one-cycle ack with the read data. */

module zap_req_hold #(
        parameter type req_t = logic [31:0]
) (
        input  logic               i_clk,
        input  logic               i_rst_n,

        // Core side.
        input  logic               i_stb,
        input  req_t               i_req,
        output logic               o_ack,
        output zap_bus_pkg::word_t o_rdat,

        // Merger side.
        output logic               o_pending,
        output req_t               o_req,
        input  logic               i_done,
        input  zap_bus_pkg::word_t i_done_dat
);

logic               pending_q;  // Waiting for the bus.
logic               ack_q;      // One-cycle ack to the core.
req_t               req_q;
zap_bus_pkg::word_t rdat_q;
logic               take;
logic               finish;

// Accept only when neither waiting nor acking.
assign take   = i_stb && !pending_q && !ack_q;
assign finish = pending_q && i_done;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                pending_q <= 1'b0;
                ack_q     <= 1'b0;
        end
        else
        begin
                ack_q <= finish;                // Ack follows done by a cycle.
                if (take)
                        pending_q <= 1'b1;
                else if (finish)
                        pending_q <= 1'b0;
        end
end

// Payload and read data.
always_ff @(posedge i_clk)
begin
        if (take)
                req_q <= i_req;
        if (finish)
                rdat_q <= i_done_dat;
end

assign o_pending = pending_q;
assign o_req     = req_q;
assign o_ack     = ack_q;
assign o_rdat    = rdat_q;

endmodule

// File: src/zap_wb_merger.sv
/* Arbitrates the held code and data requests onto one Wishbone classic master.
   Alternating priority on a tie; returns a done pulse and the read data. */

module zap_wb_merger #(
        parameter bit BE_32_ENABLE = 1'b0
) (
        input  logic                   i_clk,
        input  logic                   i_rst_n,

        // Code holder.
        input  logic                   i_code_pending,
        input  zap_bus_pkg::code_req_t i_code_req,

        // Data holder.
        input  logic                   i_data_pending,
        input  zap_bus_pkg::data_req_t i_data_req,

        // Bus returns.
        input  logic                   i_wb_ack,
        input  zap_bus_pkg::word_t     i_wb_dat,

        // Completion toward the holders.
        output logic                   o_code_done,
        output logic                   o_data_done,
        output zap_bus_pkg::word_t     o_done_dat,

        // Wishbone master.
        output logic                   o_wb_cyc,
        output logic                   o_wb_stb,
        output logic                   o_wb_we,
        output zap_bus_pkg::word_t     o_wb_adr,
        output zap_bus_pkg::word_t     o_wb_dat,
        output zap_bus_pkg::sel_t      o_wb_sel,
        output zap_bus_pkg::cti_t      o_wb_cti,
        output logic [1:0]             o_wb_bte
);

import zap_bus_pkg::*;

// ------------------------------
// BE-32 lane helpers.
// ------------------------------

function automatic sel_t sel_reverse(input sel_t sel);
        return {sel[0], sel[1], sel[2], sel[3]};
endfunction

function automatic word_t byte_reverse(input word_t dat);
        return {dat[7:0], dat[15:8], dat[23:16], dat[31:24]};
endfunction

typedef enum logic [1:0]
{
        ST_IDLE,
        ST_BUSY,
        ST_DONE
} state_t;

state_t state_q;
logic   last_was_data;          // Port served last.
logic   gnt_data;               // Current owner is the data port.
logic   pick_code;
logic   pick_data;

// Code wins unless data is pending and code went last.
assign pick_code = i_code_pending && (!i_data_pending || last_was_data);
assign pick_data = i_data_pending && !pick_code;

// Single beats only.
assign o_wb_cti = CTI_EOB;
assign o_wb_bte = BTE_LINEAR;

// ------------------------------
// Control FSM.
// ------------------------------

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                state_q       <= ST_IDLE;
                last_was_data <= 1'b1;  // So code takes the first tie.
                gnt_data      <= 1'b0;
                o_wb_cyc      <= 1'b0;
                o_wb_stb      <= 1'b0;
                o_wb_we       <= 1'b0;
                o_code_done   <= 1'b0;
                o_data_done   <= 1'b0;
        end
        else
        begin
                o_code_done <= 1'b0;
                o_data_done <= 1'b0;

                case (state_q)
                ST_IDLE:
                begin
                        if (pick_code || pick_data)
                        begin
                                state_q  <= ST_BUSY;
                                gnt_data <= pick_data;
                                o_wb_cyc <= 1'b1;
                                o_wb_stb <= 1'b1;
                                o_wb_we  <= pick_data && i_data_req.we;
                        end
                end

                ST_BUSY:
                begin
                        // Everything holds until the slave acks.
                        if (i_wb_ack)
                        begin
                                state_q       <= ST_DONE;
                                o_wb_cyc      <= 1'b0;
                                o_wb_stb      <= 1'b0;
                                o_wb_we       <= 1'b0;
                                o_code_done   <= !gnt_data;
                                o_data_done   <= gnt_data;
                                last_was_data <= gnt_data;
                        end
                end

                ST_DONE: state_q <= ST_IDLE;    // Holder drops pending here.

                default: state_q <= ST_IDLE;
                endcase
        end
end

// ------------------------------
// Bus payload and read data.
// ------------------------------

always_ff @(posedge i_clk)
begin
        if (state_q == ST_IDLE)
        begin
                if (pick_code)
                begin
                        o_wb_adr <= i_code_req.adr & WORD_ALIGN_MASK;
                        o_wb_dat <= '0;
                        o_wb_sel <= '1;                 // Full word fetch.
                end
                else if (pick_data)
                begin
                        o_wb_adr <= i_data_req.adr;
                        o_wb_dat <= i_data_req.wdat;    // Write data is not swapped.
                        o_wb_sel <= BE_32_ENABLE ? sel_reverse(i_data_req.sel) :
                                                   i_data_req.sel;
                end
        end

        if (state_q == ST_BUSY && i_wb_ack)
        begin
                o_done_dat <= (BE_32_ENABLE && gnt_data) ? byte_reverse(i_wb_dat) :
                                                           i_wb_dat;
        end
end

endmodule

// File: src/zap_bus_front.sv
/* Bus front end of the processor: code and data request ports merged onto one
   Wishbone master, plus synchronized IRQ and FIQ. */

module zap_bus_front #(
        parameter bit BE_32_ENABLE = 1'b0
) (
        // Clock and reset.
        input  logic                i_clk,
        input  logic                i_rst_n,

        // Interrupts, level triggered.
        input  logic                i_irq,
        input  logic                i_fiq,
        output logic                o_irq,
        output logic                o_fiq,

        // Code port.
        input  logic                i_code_stb,
        input  zap_bus_pkg::word_t  i_code_adr,
        output logic                o_code_ack,
        output zap_bus_pkg::word_t  o_code_dat,

        // Data port.
        input  logic                i_data_stb,
        input  logic                i_data_we,
        input  zap_bus_pkg::sel_t   i_data_sel,
        input  zap_bus_pkg::word_t  i_data_adr,
        input  zap_bus_pkg::word_t  i_data_wdat,
        output logic                o_data_ack,
        output zap_bus_pkg::word_t  o_data_rdat,

        // Wishbone master.
        output logic                o_wb_cyc,
        output logic                o_wb_stb,
        output logic                o_wb_we,
        output zap_bus_pkg::word_t  o_wb_adr,
        output zap_bus_pkg::word_t  o_wb_dat,
        output zap_bus_pkg::sel_t   o_wb_sel,
        output zap_bus_pkg::cti_t   o_wb_cti,
        output logic [1:0]          o_wb_bte,
        input  logic                i_wb_ack,
        input  zap_bus_pkg::word_t  i_wb_dat
);

import zap_bus_pkg::*;

localparam int unsigned IRQ_WIDTH = 2;  // IRQ and FIQ.

code_req_t code_req;            // From the core.
data_req_t data_req;
code_req_t code_held;           // Stable copies toward the merger.
data_req_t data_held;
logic      code_pending;
logic      data_pending;
logic      code_done;
logic      data_done;
word_t     done_dat;

assign code_req = '{adr: i_code_adr};
assign data_req = '{adr: i_data_adr, we: i_data_we, sel: i_data_sel, wdat: i_data_wdat};

// ------------------------------
// Interrupt synchronizer.
// ------------------------------

zap_irq_sync #(.WIDTH(IRQ_WIDTH)) u_irq_sync (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_async ({i_fiq, i_irq}),
        .o_sync  ({o_fiq, o_irq})
);

// ------------------------------
// Request holders.
// ------------------------------

zap_req_hold #(.req_t(code_req_t)) u_code_hold (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stb      (i_code_stb),
        .i_req      (code_req),
        .o_ack      (o_code_ack),
        .o_rdat     (o_code_dat),
        .o_pending  (code_pending),
        .o_req      (code_held),
        .i_done     (code_done),
        .i_done_dat (done_dat)
);

zap_req_hold #(.req_t(data_req_t)) u_data_hold (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stb      (i_data_stb),
        .i_req      (data_req),
        .o_ack      (o_data_ack),
        .o_rdat     (o_data_rdat),
        .o_pending  (data_pending),
        .o_req      (data_held),
        .i_done     (data_done),
        .i_done_dat (done_dat)
);

// ------------------------------
// Bus merger.
// ------------------------------

zap_wb_merger #(.BE_32_ENABLE(BE_32_ENABLE)) u_wb_merger (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_code_pending (code_pending),
        .i_code_req     (code_held),
        .i_data_pending (data_pending),
        .i_data_req     (data_held),
        .i_wb_ack       (i_wb_ack),
        .i_wb_dat       (i_wb_dat),
        .o_code_done    (code_done),
        .o_data_done    (data_done),
        .o_done_dat     (done_dat),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_we        (o_wb_we),
        .o_wb_adr       (o_wb_adr),
        .o_wb_dat       (o_wb_dat),
        .o_wb_sel       (o_wb_sel),
        .o_wb_cti       (o_wb_cti),
        .o_wb_bte       (o_wb_bte)
);

endmodule

// File: tb/zap_wb_slave_model.sv
/* Wishbone classic memory slave for the testbench.
   Word-indexed memory with a per-transfer wait count taken from i_wait. */

module zap_wb_slave_model (
        input  logic                i_clk,
        input  logic                i_rst_n,
        input  logic                i_cyc,
        input  logic                i_stb,
        input  logic                i_we,
        input  zap_bus_pkg::word_t  i_adr,
        input  zap_bus_pkg::word_t  i_dat,
        input  zap_bus_pkg::sel_t   i_sel,
        input  logic [1:0]          i_wait,
        output logic                o_ack,
        output zap_bus_pkg::word_t  o_dat
);

timeunit 1ns;
timeprecision 1ps;

zap_bus_pkg::word_t mem [0:63];
logic               busy_q;
logic [1:0]         cnt_q;
logic               fire;

// Fill from the full byte address.
initial
        for (int i = 0; i < 64; i++)
                mem[i] = (32'(i) << 2) * 32'h9E37_79B1 ^ 32'h5A5A_0000;

assign fire = i_cyc && i_stb && !o_ack && busy_q && (cnt_q == 2'd0);

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                o_ack  <= 1'b0;
                busy_q <= 1'b0;
                cnt_q  <= 2'd0;
        end
        else
        begin
                o_ack <= fire;
                if (i_cyc && i_stb && !o_ack && !busy_q)
                begin
                        busy_q <= 1'b1;         // Start counting wait states.
                        cnt_q  <= i_wait;
                end
                else if (fire)
                        busy_q <= 1'b0;
                else if (busy_q)
                        cnt_q <= cnt_q - 2'd1;
        end
end

always @(posedge i_clk)
begin
        if (fire)
        begin
                o_dat <= mem[i_adr[7:2]];
                if (i_we)
                        for (int b = 0; b < 4; b++)
                                if (i_sel[b])
                                        mem[i_adr[7:2]][b*8 +: 8] <= i_dat[b*8 +: 8];
        end
end

endmodule

// File: tb/zap_bus_front_assert.sv
/* Wishbone protocol checks, bound into every merger instance. */

module zap_bus_front_assert (
        input logic                i_clk,
        input logic                i_rst_n,
        input logic                o_wb_cyc,
        input logic                o_wb_stb,
        input zap_bus_pkg::word_t  o_wb_adr,
        input zap_bus_pkg::sel_t   o_wb_sel,
        input logic                i_wb_ack,
        input logic                i_code_pending,
        input logic                i_data_pending,
        input logic                o_code_done,
        input logic                o_data_done
);

timeunit 1ns;
timeprecision 1ps;

int fail_cnt = 0;               // Failed assertion count.

// Cycle closes on the edge after the slave ack.
a_cyc_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_cyc && i_wb_ack) |=> !o_wb_cyc)
        else
        begin
                $error("bus cycle still open after the slave ack");
                fail_cnt++;
        end

// Payload holds through wait states.
a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr) && $stable(o_wb_sel)))
        else
        begin
                $error("bus payload changed before the slave ack");
                fail_cnt++;
        end

// Done goes to a pending holder, one cycle after a bus ack.
a_done_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_code_done || o_data_done) |->
                $past(o_wb_cyc && i_wb_ack) && (o_code_done ? i_code_pending : i_data_pending))
        else
        begin
                $error("done pulse without a bus ack or to an idle holder");
                fail_cnt++;
        end

endmodule

bind zap_wb_merger zap_bus_front_assert u_assert (.*);

// File: tb/tb_zap_bus_front.sv
/* Testbench for the bus front end: random code and data traffic against a
   shadow memory, interrupt delay checks, then a summary. */

module tb_zap_bus_front;

timeunit 1ns;
timeprecision 1ps;

import zap_bus_pkg::*;

localparam int CLK_PERIOD = 10;
localparam int N_CODE     = 60;
localparam int N_DATA     = 60;
localparam int IRQ_CYCLES = 200;
localparam int TIMEOUT_NS = ((N_CODE + N_DATA) * 20 + 10) * CLK_PERIOD;

// Test ids.
localparam int T_RESET = 0;
localparam int T_CODE  = 1;
localparam int T_DATA  = 2;
localparam int T_BUS   = 3;
localparam int T_IRQ   = 4;

logic i_clk, i_rst_n, i_irq, i_fiq, o_irq, o_fiq;
logic i_code_stb, o_code_ack, i_data_stb, i_data_we, o_data_ack;
word_t i_code_adr, o_code_dat, i_data_adr, i_data_wdat, o_data_rdat;
sel_t i_data_sel, o_wb_sel;
logic o_wb_cyc, o_wb_stb, o_wb_we, i_wb_ack;
word_t o_wb_adr, o_wb_dat, i_wb_dat;
cti_t o_wb_cti;
logic [1:0] o_wb_bte, wait_states;

string test_name [5] = '{"reset", "code_fetch", "data_rw", "bus_monitor", "irq_sync"};
int    errs [5];
int    checks [5];
logic [31:0] lfsr = 32'd95260;
word_t shadow [0:63];
logic  running = 1'b0;
int    wb_acks, code_acks, data_acks;

zap_bus_front #(.BE_32_ENABLE(1'b1)) u_dut (.*);

zap_wb_slave_model u_slave (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_cyc (o_wb_cyc), .i_stb (o_wb_stb),
        .i_we (o_wb_we), .i_adr (o_wb_adr), .i_dat (o_wb_dat), .i_sel (o_wb_sel),
        .i_wait (wait_states), .o_ack (i_wb_ack), .o_dat (i_wb_dat)
);

initial
begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

// ------------------------------
// Helpers and compare tasks.
// ------------------------------

function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
                r = {r[30:0], lfsr[0]};
                lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
endfunction

function automatic sel_t flip_sel(input sel_t s);
        sel_t r;
        for (int b = 0; b < 4; b++)
                r[b] = s[3-b];
        return r;
endfunction

function automatic word_t swap_bytes(input word_t w);
        word_t r;
        for (int b = 0; b < 4; b++)
                r[b*8 +: 8] = w[(3-b)*8 +: 8];
        return r;
endfunction

task automatic check_word(input int id, input string what, input word_t exp, input word_t act);
        checks[id]++;
        if (exp !== act)
        begin
                errs[id]++;
                $display("** Error %s %s: expected %h, actual %h", test_name[id], what, exp, act);
        end
endtask

task automatic check_sel(input int id, input string what, input sel_t exp, input sel_t act);
        checks[id]++;
        if (exp !== act)
        begin
                errs[id]++;
                $display("** Error %s %s: expected %h, actual %h", test_name[id], what, exp, act);
        end
endtask

task automatic check_cti(input int id, input string what, input cti_t exp, input cti_t act);
        checks[id]++;
        if (exp !== act)
        begin
                errs[id]++;
                $display("** Error %s %s: expected %b, actual %b", test_name[id], what, exp, act);
        end
endtask

task automatic check_bte(input int id, input string what, input logic [1:0] exp,
                         input logic [1:0] act);
        checks[id]++;
        if (exp !== act)
        begin
                errs[id]++;
                $display("** Error %s %s: expected %b, actual %b", test_name[id], what, exp, act);
        end
endtask

task automatic check_logic(input int id, input string what, input logic exp, input logic act);
        checks[id]++;
        if (exp !== act)
        begin
                errs[id]++;
                $display("** Error %s %s: expected %b, actual %b", test_name[id], what, exp, act);
        end
endtask

task automatic report(input int id);
        $display("%-12s %0d checks, %0d errors", test_name[id], checks[id], errs[id]);
endtask

task automatic check_idle_outputs();
        check_logic(T_RESET, "o_wb_cyc", 1'b0, o_wb_cyc);
        check_logic(T_RESET, "o_wb_stb", 1'b0, o_wb_stb);
        check_logic(T_RESET, "o_wb_we", 1'b0, o_wb_we);
        check_logic(T_RESET, "o_code_ack", 1'b0, o_code_ack);
        check_logic(T_RESET, "o_data_ack", 1'b0, o_data_ack);
        check_logic(T_RESET, "o_irq", 1'b0, o_irq);
        check_logic(T_RESET, "o_fiq", 1'b0, o_fiq);
endtask

// ------------------------------
// Stimulus processes.
// ------------------------------

task automatic run_code();
        int idx;
        for (int i = 0; i < N_CODE; i++)
        begin
                repeat (rand_bits(2)) @(posedge i_clk);
                @(posedge i_clk);
                i_code_stb <= 1'b1;
                i_code_adr <= {24'h0, 1'b0, 7'(rand_bits(7))};    // Code region.
                @(posedge i_clk);
                while (!o_code_ack)
                        @(posedge i_clk);
                idx = i_code_adr[7:2];
                check_word(T_CODE, "fetch data", shadow[idx], o_code_dat);
                i_code_stb <= 1'b0;
        end
endtask

task automatic run_data();
        int    idx;
        sel_t  bsel;
        for (int i = 0; i < N_DATA; i++)
        begin
                repeat (rand_bits(2)) @(posedge i_clk);
                @(posedge i_clk);
                i_data_stb  <= 1'b1;
                i_data_adr  <= {24'h0, 1'b1, 7'(rand_bits(7))};   // Data region.
                i_data_we   <= 1'(rand_bits(1));
                i_data_sel  <= 4'(rand_bits(4));
                i_data_wdat <= rand_bits(32);
                @(posedge i_clk);
                while (!o_data_ack)
                        @(posedge i_clk);
                idx  = i_data_adr[7:2];
                bsel = flip_sel(i_data_sel);
                if (i_data_we)
                begin
                        for (int b = 0; b < 4; b++)
                                if (bsel[b])
                                        shadow[idx][b*8 +: 8] = i_data_wdat[b*8 +: 8];
                end
                else
                        check_word(T_DATA, "read data", swap_bytes(shadow[idx]), o_data_rdat);
                i_data_stb <= 1'b0;
        end
endtask

task automatic run_irq();
        logic [1:0] hist [$];
        for (int i = 0; i < IRQ_CYCLES; i++)
        begin
                @(posedge i_clk);
                hist.push_back({i_fiq, i_irq});
                if (hist.size() >= 3)
                begin
                        check_logic(T_IRQ, "o_irq", hist[$-2][0], o_irq);
                        check_logic(T_IRQ, "o_fiq", hist[$-2][1], o_fiq);
                end
                i_irq <= 1'(rand_bits(1));
                i_fiq <= 1'(rand_bits(1));
        end
endtask

// Bus monitor and wait-state source.
always @(posedge i_clk)
begin
        if (running)
        begin
                wait_states <= 2'(rand_bits(2));
                wb_acks   += i_wb_ack;
                code_acks += o_code_ack;
                data_acks += o_data_ack;
                check_logic(T_BUS, "ack order", 1'b1, code_acks + data_acks <= wb_acks);
                if (o_wb_cyc)
                begin
                        check_cti(T_BUS, "cti", 3'b111, o_wb_cti);      // End of burst.
                        check_bte(T_BUS, "bte", 2'b00, o_wb_bte);
                end
                if (o_wb_cyc && o_wb_stb && !o_wb_adr[7])
                begin
                        check_word(T_BUS, "code adr", {i_code_adr[31:2], 2'b00}, o_wb_adr);
                        check_sel(T_BUS, "code sel", 4'hF, o_wb_sel);
                        check_logic(T_BUS, "code we", 1'b0, o_wb_we);
                end
                else if (o_wb_cyc && o_wb_stb)
                begin
                        check_word(T_BUS, "data adr", i_data_adr, o_wb_adr);
                        check_sel(T_BUS, "data sel", flip_sel(i_data_sel), o_wb_sel);
                        check_logic(T_BUS, "data we", i_data_we, o_wb_we);
                        if (i_data_we)
                                check_word(T_BUS, "wdat", i_data_wdat, o_wb_dat);
                end
        end
end

// Watchdog.
initial
begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the transfers did not finish in time.");
        $display("*** FAILED ***");
        $finish;
end

initial
begin
        int total;
        i_rst_n = 1'b0;
        i_irq = 1'b0;
        i_fiq = 1'b0;
        i_code_stb = 1'b0;
        i_code_adr = '0;
        i_data_stb = 1'b0;
        i_data_we = 1'b0;
        i_data_sel = '0;
        i_data_adr = '0;
        i_data_wdat = '0;
        wait_states = 2'd0;
        wb_acks = 0;
        code_acks = 0;
        data_acks = 0;
        for (int i = 0; i < 64; i++)
                shadow[i] = (32'(i) << 2) * 32'h9E37_79B1 ^ 32'h5A5A_0000;

        repeat (4)
        begin
                @(posedge i_clk);
                check_idle_outputs();
        end
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        check_idle_outputs();
        report(T_RESET);

        running = 1'b1;
        fork
                run_code();
                run_data();
                run_irq();
        join
        repeat (4) @(posedge i_clk);
        running = 1'b0;
        check_word(T_CODE, "ack count", N_CODE, code_acks);
        check_word(T_DATA, "ack count", N_DATA, data_acks);
        report(T_CODE);
        report(T_DATA);
        report(T_BUS);
        report(T_IRQ);

        total = 0;
        foreach (errs[i])
                total += errs[i];
        total += u_dut.u_wb_merger.u_assert.fail_cnt;
        $display("Tests: 5, checks: %0d, errors: %0d", checks.sum(), total);
        if (total == 0)
                $display("*** PASSED ***");
        else
                $display("*** FAILED ***");
        $finish;
end

endmodule

// File: zap_bus_front.f
src/zap_bus_pkg.sv
src/zap_irq_sync.sv
src/zap_req_hold.sv
src/zap_wb_merger.sv
src/zap_bus_front.sv
tb/zap_wb_slave_model.sv
tb/zap_bus_front_assert.sv
tb/tb_zap_bus_front.sv

// File: Bender.yml
package:
  name: zap_bus_front

sources:
  - src/zap_bus_pkg.sv
  - src/zap_irq_sync.sv
  - src/zap_req_hold.sv
  - src/zap_wb_merger.sv
  - src/zap_bus_front.sv
  - target: test
    files:
      - tb/zap_wb_slave_model.sv
      - tb/zap_bus_front_assert.sv
      - tb/tb_zap_bus_front.sv
